/* bench/sub_mult_abs_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sub_mult_abs_tb import fixed_point_pkg::*, axis_frame_pkg::*; ();

  localparam int wait_limit = 500;

  logic         clk;
  logic         rst;
  sample_beat_t x_beat;
  logic         x_valid;
  logic         x_ready;
  sample_beat_t g_beat;
  logic         g_valid;
  logic         g_ready;
  scale_beat_t  s_beat;
  logic         s_valid;
  logic         s_ready;
  rslt_beat_t   rslt_beat;
  logic         rslt_valid;
  logic         rslt_ready;

  int seed;
  int errors;

  // Values of the frame being built, one queue per stream
  sample_t xv[$];
  sample_t gv[$];
  scale_t  sv[$];

  sample_beat_t x_q[$];
  sample_beat_t g_q[$];
  scale_beat_t  s_q[$];
  rslt_beat_t   exp_q[$];

  sub_mult_abs sub_mult_abs_inst (
    .clk(clk), .rst(rst),
    .x_beat(x_beat), .x_valid(x_valid), .x_ready(x_ready),
    .g_beat(g_beat), .g_valid(g_valid), .g_ready(g_ready),
    .s_beat(s_beat), .s_valid(s_valid), .s_ready(s_ready),
    .rslt_beat(rslt_beat), .rslt_valid(rslt_valid), .rslt_ready(rslt_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Test failed");
    $finish;
  endtask

  // abs((x - g) * s) in Q4.12, round half up, then signed and unsigned clipping
  function automatic rslt_t expected_magnitude(input sample_t x, input sample_t g,
                                               input scale_t s);
    longint prod;
    longint scaled;
    prod   = (longint'(x) - longint'(g)) * longint'(s);
    scaled = (prod + (longint'(1) << (rescale_shift - 1))) >>> rescale_shift;
    if (scaled > 65535) scaled = 65535;
    if (scaled < -65536) scaled = -65536;
    if (scaled < 0) scaled = -scaled;
    if (scaled > 65535) scaled = 65535;
    return rslt_t'(scaled);
  endfunction

  task automatic check_rslt_beat(input rslt_beat_t got, input rslt_beat_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: result %0d last %0b, expected %0d last %0b",
               $time, got.data, got.last, exp.data, exp.last);
    end
  endtask

  task automatic add_triple(input sample_t x, input sample_t g, input scale_t s);
    xv.push_back(x);
    gv.push_back(g);
    sv.push_back(s);
  endtask

  task automatic fill_random(input int nx, input int ng, input int ns);
    repeat (nx) xv.push_back(sample_t'($random(seed) % 8192));
    repeat (ng) gv.push_back(sample_t'($random(seed) % 8192));
    repeat (ns) sv.push_back(scale_t'($random(seed) % 8192));
  endtask

  // Turns the staged values into input beats and expected results
  task automatic queue_frame();
    int           n;
    sample_beat_t xb;
    sample_beat_t gb;
    scale_beat_t  sb;
    rslt_beat_t   eb;
    n = xv.size();
    if (gv.size() > n) n = gv.size();
    if (sv.size() > n) n = sv.size();
    foreach (xv[i]) begin
      xb.data = xv[i];
      xb.last = (i == xv.size() - 1);
      x_q.push_back(xb);
    end
    foreach (gv[i]) begin
      gb.data = gv[i];
      gb.last = (i == gv.size() - 1);
      g_q.push_back(gb);
    end
    foreach (sv[i]) begin
      sb.data = sv[i];
      sb.last = (i == sv.size() - 1);
      s_q.push_back(sb);
    end
    for (int i = 0; i < n; i++) begin
      // Shorter streams repeat their final value
      eb.data = expected_magnitude(xv[(i < xv.size()) ? i : xv.size() - 1],
                                   gv[(i < gv.size()) ? i : gv.size() - 1],
                                   sv[(i < sv.size()) ? i : sv.size() - 1]);
      eb.last = (i == n - 1);
      exp_q.push_back(eb);
    end
    xv.delete();
    gv.delete();
    sv.delete();
  endtask

  task automatic drive_x();
    int waited;
    while (x_q.size() > 0) begin
      @(posedge clk);
      x_beat  <= x_q.pop_front();
      x_valid <= 1'b1;
      waited = 0;
      @(negedge clk);
      while (!x_ready) begin
        waited++;
        if (waited > wait_limit) abort_on_timeout("the x input to be accepted");
        @(negedge clk);
      end
    end
    @(posedge clk);
    x_valid <= 1'b0;
  endtask

  task automatic drive_g();
    int waited;
    while (g_q.size() > 0) begin
      @(posedge clk);
      g_beat  <= g_q.pop_front();
      g_valid <= 1'b1;
      waited = 0;
      @(negedge clk);
      while (!g_ready) begin
        waited++;
        if (waited > wait_limit) abort_on_timeout("the g input to be accepted");
        @(negedge clk);
      end
    end
    @(posedge clk);
    g_valid <= 1'b0;
  endtask

  task automatic drive_s();
    int waited;
    while (s_q.size() > 0) begin
      @(posedge clk);
      s_beat  <= s_q.pop_front();
      s_valid <= 1'b1;
      waited = 0;
      @(negedge clk);
      while (!s_ready) begin
        waited++;
        if (waited > wait_limit) abort_on_timeout("the s input to be accepted");
        @(negedge clk);
      end
    end
    @(posedge clk);
    s_valid <= 1'b0;
  endtask

  task automatic collect_results(input bit random_ready);
    int idle;
    idle = 0;
    while (exp_q.size() > 0) begin
      @(posedge clk);
      rslt_ready <= random_ready ? (($random(seed) % 2) != 0) : 1'b1;
      @(negedge clk);
      if (rslt_valid && rslt_ready) begin
        check_rslt_beat(rslt_beat, exp_q.pop_front());
        idle = 0;
      end else begin
        idle++;
        if (idle > wait_limit) abort_on_timeout("the next result beat");
      end
    end
    @(posedge clk);
    rslt_ready <= 1'b1;
    // Pipeline should be empty now
    repeat (6) begin
      @(negedge clk);
      if (rslt_valid) begin
        errors++;
        $display("Unexpected extra result beat at %0t", $time);
      end
    end
  endtask

  task automatic run_traffic(input bit random_ready);
    fork
      drive_x();
      drive_g();
      drive_s();
      collect_results(random_ready);
    join
  endtask

  task automatic test_equal_frames();
    // x - g of 1.0, -1.0, 0 and -1.25 against s of 1.0 and -0.5
    add_triple(16'h2000, 16'h1000, 16'h1000);
    add_triple(16'h0800, 16'h1800, 16'hF800);
    add_triple(16'h1000, 16'h1000, 16'h1000);
    add_triple(16'hF000, 16'h0400, 16'hF800);
    queue_frame();
    run_traffic(1'b0);
  endtask

  task automatic test_round_saturate();
    // One LSB times 0.5 lands exactly on half an output LSB
    add_triple(16'h0001, 16'h0000, 16'h0800);
    add_triple(16'h0000, 16'h0001, 16'h0800);
    add_triple(16'h7FFF, 16'h8000, 16'h7FFF);
    add_triple(16'h8000, 16'h7FFF, 16'h7FFF);
    queue_frame();
    run_traffic(1'b0);
  endtask

  task automatic test_unequal_lengths();
    fill_random(5, 0, 0);
    gv.push_back(16'h0C00);
    gv.push_back(16'hF400);
    sv.push_back(16'h1000);
    sv.push_back(16'h2000);
    sv.push_back(16'hE000);
    queue_frame();
    run_traffic(1'b0);
  endtask

  task automatic test_back_pressure();
    fill_random(20, 20, 20);
    queue_frame();
    run_traffic(1'b1);
  endtask

  task automatic test_back_to_back();
    // Shortest stream moves from g to x to x and g
    fill_random(3, 1, 2);
    queue_frame();
    fill_random(1, 4, 2);
    queue_frame();
    fill_random(2, 2, 5);
    queue_frame();
    run_traffic(1'b0);
  endtask

  initial begin
    seed       = 9;
    errors     = 0;
    rst        = 1'b1;
    x_beat     = '0;
    x_valid    = 1'b0;
    g_beat     = '0;
    g_valid    = 1'b0;
    s_beat     = '0;
    s_valid    = 1'b0;
    rslt_ready = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_equal_frames();
    test_round_saturate();
    test_unequal_lengths();
    test_back_pressure();
    test_back_to_back();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the sub_mult_abs testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module sub_mult_abs_tb -f src.f; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vsub_mult_abs_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* source/axis_frame_pkg.sv */
`default_nettype none

package axis_frame_pkg;

  import fixed_point_pkg::*;

  // Used by both the x and g inputs
  typedef struct packed {
    sample_t data;
    logic    last;
  } sample_beat_t;

  typedef struct packed {
    scale_t data;
    logic   last;
  } scale_beat_t;

  // Aligned triple leaving the joiner
  typedef struct packed {
    sample_t x;
    sample_t g;
    scale_t  s;
    logic    last;
  } joined_beat_t;

  // Between arithmetic and magnitude stage
  typedef struct packed {
    signed_rslt_t data;
    logic         last;
  } signed_beat_t;

  typedef struct packed {
    rslt_t data;
    logic  last;
  } rslt_beat_t;

endpackage

`default_nettype wire

/* source/fixed_point_pkg.sv */
`default_nettype none

package fixed_point_pkg;

  // Samples and grid, signed Q4.12
  localparam int data_width     = 16;
  localparam int data_frac_bits = 12;

  // Scale, signed Q4.12
  localparam int scale_width     = 16;
  localparam int scale_frac_bits = 12;

  // Result, unsigned Q4.12 after the magnitude stage
  localparam int rslt_width     = 16;
  localparam int rslt_frac_bits = 12;

  // Product carries data_frac_bits + scale_frac_bits fractional bits
  localparam int rescale_shift = data_frac_bits + scale_frac_bits - rslt_frac_bits;

  typedef logic signed [data_width-1:0]  sample_t;
  typedef logic signed [scale_width-1:0] scale_t;

  // Exact difference of two samples needs one extra bit
  typedef logic signed [data_width:0] diff_t;

  // Full product of diff_t and scale_t, no bits lost
  typedef logic signed [data_width+scale_width:0] product_t;

  // One bit wider than the output so the sign survives until abs
  typedef logic signed [rslt_width:0] signed_rslt_t;

  typedef logic [rslt_width-1:0] rslt_t;

  // Half an output LSB, added before the shift for round-half-up
  localparam product_t round_const = product_t'(2 ** (rescale_shift - 1));

  // Limits of signed_rslt_t, expressed at product width
  localparam product_t sat_max = product_t'(2 ** rslt_width - 1);
  localparam product_t sat_min = -product_t'(2 ** rslt_width);

  // Largest unsigned result
  localparam rslt_t rslt_max = {rslt_width{1'b1}};

endpackage

`default_nettype wire

/* source/frame_extend_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_extend_lane import axis_frame_pkg::*; #(
  parameter type beat_t = sample_beat_t
) (
  input  logic  clk,
  input  logic  rst,

  // Upstream stream
  input  beat_t in_beat,
  input  logic  in_valid,
  output logic  in_ready,

  // Towards the joiner
  output beat_t beat,
  output logic  valid,
  output logic  ended,
  input  logic  take,
  input  logic  frame_end
);

  beat_t hold_q;
  beat_t held_beat;
  logic  ended_q;

  // Repeated beat never carries last, the joiner decides end of frame
  always_comb begin
    held_beat      = hold_q;
    held_beat.last = 1'b0;
  end

  assign beat     = ended_q ? held_beat : in_beat;
  assign valid    = ended_q | in_valid;
  assign ended    = ended_q;
  // Next frame waits while this lane repeats its final beat
  assign in_ready = take & ~ended_q;

  always_ff @(posedge clk) begin
    if (take && !ended_q) begin
      hold_q <= in_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ended_q <= 1'b0;
    end else if (frame_end) begin
      // Also covers a lane whose last arrives on the closing take
      ended_q <= 1'b0;
    end else if (take && !ended_q && in_beat.last) begin
      ended_q <= 1'b1;
    end
  end

  // Joiner only takes when every lane presents a beat
  take_needs_valid: assert property (
    @(posedge clk) disable iff (rst) take |-> valid
  );

endmodule

`default_nettype wire

/* source/frame_join3.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_join3 import axis_frame_pkg::*; (
  input  logic         clk,
  input  logic         rst,

  // Lane beats
  input  sample_beat_t x,
  input  sample_beat_t g,
  input  scale_beat_t  s,
  input  logic         x_valid,
  input  logic         g_valid,
  input  logic         s_valid,
  input  logic         x_ended,
  input  logic         g_ended,
  input  logic         s_ended,

  // Back to the lanes
  output logic         take,
  output logic         frame_end,

  // Joined stream
  output joined_beat_t out_beat,
  output logic         out_valid,
  input  logic         out_ready
);

  joined_beat_t out_q;
  logic         out_valid_q;
  logic         all_valid;
  logic         frame_done;

  assign all_valid = x_valid & g_valid & s_valid;

  // Frame closes once no lane has more beats to come
  assign frame_done = (x_ended | x.last) & (g_ended | g.last) & (s_ended | s.last);

  // Register free, or being emptied this cycle
  assign take      = all_valid & (~out_valid_q | out_ready);
  assign frame_end = take & frame_done;

  always_ff @(posedge clk) begin
    if (take) begin
      out_q.x    <= x.data;
      out_q.g    <= g.data;
      out_q.s    <= s.data;
      out_q.last <= frame_done;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q <= 1'b0;
    end else if (take) begin
      out_valid_q <= 1'b1;
    end else if (out_ready) begin
      out_valid_q <= 1'b0;
    end
  end

  assign out_beat  = out_q;
  assign out_valid = out_valid_q;

  // Payload held while the arithmetic stalls
  join_stable_on_stall: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> $stable(out_beat)
  );

endmodule

`default_nettype wire

/* source/magnitude_saturate.sv */
`timescale 1ns/1ps
`default_nettype none

module magnitude_saturate import fixed_point_pkg::*, axis_frame_pkg::*; (
  input  logic         clk,
  input  logic         rst,

  input  signed_beat_t in_beat,
  input  logic         in_valid,
  output logic         in_ready,

  output rslt_beat_t   out_beat,
  output logic         out_valid,
  input  logic         out_ready
);

  rslt_beat_t        out_q;
  logic              out_valid_q;
  logic [rslt_width:0] mag;
  rslt_t             clipped;

  // Most negative input gives 2**rslt_width, which still fits here
  always_comb begin
    if (in_beat.data[rslt_width]) begin
      mag = -in_beat.data;
    end else begin
      mag = in_beat.data;
    end
    clipped = (mag > {1'b0, rslt_max}) ? rslt_max : mag[rslt_width-1:0];
  end

  assign in_ready = ~out_valid_q | out_ready;

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_q.data <= clipped;
      out_q.last <= in_beat.last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q <= 1'b0;
    end else if (in_ready) begin
      out_valid_q <= in_valid;
    end
  end

  assign out_beat  = out_q;
  assign out_valid = out_valid_q;

  output_stable_on_stall: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat)
  );

endmodule

`default_nettype wire

/* source/sub_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module sub_mult import fixed_point_pkg::*, axis_frame_pkg::*; (
  input  logic         clk,
  input  logic         rst,

  input  joined_beat_t in_beat,
  input  logic         in_valid,
  output logic         in_ready,

  output signed_beat_t out_beat,
  output logic         out_valid,
  input  logic         out_ready
);

  // Stage 1 registers
  diff_t  s1_diff;
  scale_t s1_scale;
  logic   s1_last;
  logic   s1_valid;
  logic   s1_ready;

  // Stage 2 registers
  signed_beat_t s2_q;
  logic         s2_valid;

  // Stage 1 combinational
  diff_t x_ext;
  diff_t g_ext;
  diff_t diff;

  // Stage 2 combinational
  product_t product;
  product_t rounded;
  product_t shifted;
  signed_rslt_t sat;

  always_comb begin
    x_ext = diff_t'(in_beat.x);
    g_ext = diff_t'(in_beat.g);
    diff  = x_ext - g_ext;
  end

  assign s1_ready = ~s2_valid | out_ready;
  assign in_ready = ~s1_valid | s1_ready;

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      s1_diff  <= diff;
      s1_scale <= in_beat.s;
      s1_last  <= in_beat.last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (in_ready) begin
      s1_valid <= in_valid;
    end
  end

  always_comb begin
    product = product_t'(s1_diff) * product_t'(s1_scale);
    // Round half up, then drop the extra fractional bits
    rounded = product + round_const;
    shifted = rounded >>> rescale_shift;
    if (shifted > sat_max) begin
      sat = signed_rslt_t'(sat_max);
    end else if (shifted < sat_min) begin
      sat = signed_rslt_t'(sat_min);
    end else begin
      sat = signed_rslt_t'(shifted);
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid && s1_ready) begin
      s2_q.data <= sat;
      s2_q.last <= s1_last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else if (s1_ready) begin
      s2_valid <= s1_valid;
    end
  end

  assign out_beat  = s2_q;
  assign out_valid = s2_valid;

  // A result is never withdrawn before the magnitude stage takes it
  result_valid_held: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid
  );

endmodule

`default_nettype wire

/* source/sub_mult_abs.sv */
`timescale 1ns/1ps
`default_nettype none

module sub_mult_abs import axis_frame_pkg::*; (
  input  logic         clk,
  input  logic         rst,

  // Samples
  input  sample_beat_t x_beat,
  input  logic         x_valid,
  output logic         x_ready,

  // Grid
  input  sample_beat_t g_beat,
  input  logic         g_valid,
  output logic         g_ready,

  // Scale
  input  scale_beat_t  s_beat,
  input  logic         s_valid,
  output logic         s_ready,

  // abs((x - g) * s)
  output rslt_beat_t   rslt_beat,
  output logic         rslt_valid,
  input  logic         rslt_ready
);

  sample_beat_t x_lane_beat;
  sample_beat_t g_lane_beat;
  scale_beat_t  s_lane_beat;
  logic         x_lane_valid;
  logic         g_lane_valid;
  logic         s_lane_valid;
  logic         x_ended;
  logic         g_ended;
  logic         s_ended;
  logic         take;
  logic         frame_end;

  joined_beat_t joined_beat;
  logic         joined_valid;
  logic         joined_ready;

  signed_beat_t signed_beat;
  logic         signed_valid;
  logic         signed_ready;

  frame_extend_lane #(.beat_t(sample_beat_t)) x_lane (
    .clk(clk), .rst(rst),
    .in_beat(x_beat), .in_valid(x_valid), .in_ready(x_ready),
    .beat(x_lane_beat), .valid(x_lane_valid), .ended(x_ended),
    .take(take), .frame_end(frame_end)
  );

  frame_extend_lane #(.beat_t(sample_beat_t)) g_lane (
    .clk(clk), .rst(rst),
    .in_beat(g_beat), .in_valid(g_valid), .in_ready(g_ready),
    .beat(g_lane_beat), .valid(g_lane_valid), .ended(g_ended),
    .take(take), .frame_end(frame_end)
  );

  frame_extend_lane #(.beat_t(scale_beat_t)) s_lane (
    .clk(clk), .rst(rst),
    .in_beat(s_beat), .in_valid(s_valid), .in_ready(s_ready),
    .beat(s_lane_beat), .valid(s_lane_valid), .ended(s_ended),
    .take(take), .frame_end(frame_end)
  );

  frame_join3 frame_join3_inst (
    .clk(clk), .rst(rst),
    .x(x_lane_beat), .g(g_lane_beat), .s(s_lane_beat),
    .x_valid(x_lane_valid), .g_valid(g_lane_valid), .s_valid(s_lane_valid),
    .x_ended(x_ended), .g_ended(g_ended), .s_ended(s_ended),
    .take(take), .frame_end(frame_end),
    .out_beat(joined_beat), .out_valid(joined_valid), .out_ready(joined_ready)
  );

  sub_mult sub_mult_inst (
    .clk(clk), .rst(rst),
    .in_beat(joined_beat), .in_valid(joined_valid), .in_ready(joined_ready),
    .out_beat(signed_beat), .out_valid(signed_valid), .out_ready(signed_ready)
  );

  magnitude_saturate magnitude_saturate_inst (
    .clk(clk), .rst(rst),
    .in_beat(signed_beat), .in_valid(signed_valid), .in_ready(signed_ready),
    .out_beat(rslt_beat), .out_valid(rslt_valid), .out_ready(rslt_ready)
  );

endmodule

`default_nettype wire

/* src.f */
source/fixed_point_pkg.sv
source/axis_frame_pkg.sv
source/frame_extend_lane.sv
source/frame_join3.sv
source/sub_mult.sv
source/magnitude_saturate.sv
source/sub_mult_abs.sv
bench/sub_mult_abs_tb.sv
